// ==== hdl/mmu_tlb_pkg.sv ====
// Address types, TLB kinds, entry widths and field positions of the four TLBs.
package mmu_tlb_pkg;

        typedef logic [31:0] va_t;      // Virtual or physical address.
        typedef logic [2:0]  tlb_idx_t; // Entry index.
        typedef logic [3:0]  dom_t;     // Domain number.

        typedef enum logic [1:0]
        {
                SECTION,                // 1 MB.
                LPAGE,                  // 64 KB.
                SPAGE,                  // 4 KB.
                FPAGE                   // 1 KB.
        } tlb_kind_t;

        localparam int TLB_ENTRIES = 8;
        localparam int IDX_W       = $bits(tlb_idx_t);

        // ----------------------------------------
        // Entry widths.
        // ----------------------------------------
        localparam int SE_TLB_WDT = 29;
        localparam int LP_TLB_WDT = 43;
        localparam int SP_TLB_WDT = 51; // Widest one sets the write bus.
        localparam int FP_TLB_WDT = 49;

        // Entry is {tag, base, domain, AP, CB}, tag at the top.
        localparam int CB_C_BIT = 1;    // C of the CB pair.
        localparam int AP_LO    = 2;    // AP starts above CB.

        localparam int SE_TAG_LO  = 20; // Tag VA[31:23].
        localparam int SE_BASE_LO = 8;  // Base PA[31:20].
        localparam int SE_DOM_LO  = 4;

        localparam int LP_TAG_LO  = 30; // Tag VA[31:19].
        localparam int LP_BASE_LO = 14; // Base PA[31:16].
        localparam int LP_DOM_LO  = 10; // Four AP fields below.

        localparam int SP_TAG_LO  = 34; // Tag VA[31:15].
        localparam int SP_BASE_LO = 14; // Base PA[31:12].
        localparam int SP_DOM_LO  = 10;

        localparam int FP_TAG_LO  = 30; // Tag VA[31:13].
        localparam int FP_BASE_LO = 8;  // Base PA[31:10].
        localparam int FP_DOM_LO  = 4;

        // ----------------------------------------
        // VA fields. Index LSB doubles as offset width.
        // ----------------------------------------
        localparam int SE_IDX_LO   = 20;
        localparam int LP_IDX_LO   = 16;
        localparam int SP_IDX_LO   = 12;
        localparam int FP_IDX_LO   = 10;
        localparam int LP_APSEL_LO = 14; // VA[15:14].
        localparam int SP_APSEL_LO = 10; // VA[11:10].

endpackage

// ==== hdl/mmu_access_pkg.sv ====
// Access classes, domain codes, fault status codes and the register map.
package mmu_access_pkg;

        typedef logic [3:0] apsr_t;     // {AP, S, R}.
        typedef logic [7:0] fsr_t;      // {domain, status}.

        typedef enum logic [1:0]
        {
                AXIL_IDLE,              // Wait for AW and W.
                AXIL_ACK,               // Readies high, write lands.
                AXIL_RESP               // BVALID until BREADY.
        } axil_state_t;

        // ----------------------------------------
        // AP/SR classes matched with casez.
        // ----------------------------------------
        localparam apsr_t APSR_NA_NA = 4'b00_00;
        localparam apsr_t APSR_RO_NA = 4'b00_10;        // S set.
        localparam apsr_t APSR_RO_RO = 4'b00_?1;        // R set.
        localparam apsr_t APSR_RW_NA = 4'b01_??;
        localparam apsr_t APSR_RW_RO = 4'b10_??;
        localparam apsr_t APSR_RW_RW = 4'b11_??;

        localparam logic [1:0] DAC_NOACCESS = 2'b00;
        localparam logic [1:0] DAC_CLIENT   = 2'b01;
        localparam logic [1:0] DAC_MANAGER  = 2'b11;

        localparam logic [3:0] FSR_SECTION_DOMAIN = 4'h9;
        localparam logic [3:0] FSR_PAGE_DOMAIN    = 4'hB;
        localparam logic [3:0] FSR_SECTION_PERM   = 4'hD;
        localparam logic [3:0] FSR_PAGE_PERM      = 4'hF;

        // ----------------------------------------
        // Register map.
        // ----------------------------------------
        localparam logic [4:0] REG_CTRL     = 5'h00;
        localparam logic [4:0] REG_DAC      = 5'h04;
        localparam logic [4:0] REG_ENTRY_LO = 5'h08;
        localparam logic [4:0] REG_ENTRY_HI = 5'h0C;
        localparam logic [4:0] REG_TLB_CMD  = 5'h10;    // Write only.

        localparam int CTRL_EN_BIT   = 0;
        localparam int CTRL_SR_LO    = 1;               // Bit 2 S, bit 1 R.
        localparam int CMD_KIND_LO   = 0;
        localparam int CMD_IDX_LO    = 2;
        localparam int CMD_WR_BIT    = 8;
        localparam int CMD_FLUSH_BIT = 9;

endpackage

// ==== hdl/tlb_ram.sv ====
// Direct-mapped TLB with valid bits, registered read, write port and flush.
`timescale 1ns/1ps

module tlb_ram
        import mmu_tlb_pkg::*;
#(
        parameter int WDT = SE_TLB_WDT          // Entry width.
)
(
        input  logic           i_clk,
        input  logic           i_rst,
        input  tlb_idx_t       i_rd_idx,        // From lookup VA.
        input  logic           i_wr_en,
        input  tlb_idx_t       i_wr_idx,
        input  logic [WDT-1:0] i_wr_data,
        input  logic           i_flush,         // Drop all entries.
        output logic [WDT-1:0] o_rdata,
        output logic           o_rdav           // Entry valid.
);

logic [WDT-1:0]         mem [TLB_ENTRIES];      // Entry storage.
logic [TLB_ENTRIES-1:0] valid;

always_ff @(posedge i_clk)
begin
        if (i_wr_en)
                mem[i_wr_idx] <= i_wr_data;
        o_rdata <= mem[i_rd_idx];               // Old data on same-edge write.
end

always_ff @(posedge i_clk)
begin
        if (i_rst)
        begin
                valid  <= '0;
                o_rdav <= 1'b0;
        end
        else
        begin
                if (i_flush)
                        valid <= '0;            // One-cycle flush.
                else if (i_wr_en)
                        valid[i_wr_idx] <= 1'b1;
                o_rdav <= valid[i_rd_idx];
        end
end

endmodule

// ==== hdl/tlb_check.sv ====
// Request stage, TLB hit search, domain and permission check, lookup result.
`timescale 1ns/1ps

module tlb_check
        import mmu_tlb_pkg::*, mmu_access_pkg::*;
(
        input  logic                  i_clk,
        input  logic                  i_rst,
        input  logic                  i_lu_valid,
        input  va_t                   i_lu_va,
        input  logic                  i_lu_rd,
        input  logic                  i_lu_wr,
        input  logic                  i_lu_user,        // 1 is user mode.
        input  logic                  i_mmu_en,
        input  logic [1:0]            i_sr,             // {S, R}.
        input  logic [31:0]           i_dac_reg,        // 16 domain codes.
        input  logic [SP_TLB_WDT-1:0] i_sptlb_rdata,
        input  logic                  i_sptlb_rdav,
        input  logic [LP_TLB_WDT-1:0] i_lptlb_rdata,
        input  logic                  i_lptlb_rdav,
        input  logic [SE_TLB_WDT-1:0] i_setlb_rdata,
        input  logic                  i_setlb_rdav,
        input  logic [FP_TLB_WDT-1:0] i_fptlb_rdata,
        input  logic                  i_fptlb_rdav,
        output logic                  o_lu_valid,
        output va_t                   o_lu_pa,
        output fsr_t                  o_lu_fsr,
        output va_t                   o_lu_far,
        output logic                  o_lu_walk,
        output logic                  o_lu_cacheable
);

logic       lu_valid_q;
va_t        va_q;               // Request, aligned with TLB read.
logic       rd_q;
logic       wr_q;
logic       user_q;
logic       sp_hit;
logic       lp_hit;
logic       se_hit;
logic       fp_hit;
logic       hit;                // Some TLB hit.
logic       section;            // Hit is a section.
dom_t       dom;                // Domain of the hit entry.
logic [1:0] ap;                 // Selected AP field.
logic [1:0] dac;                // Domain access code.

// ----------------------------------------
// Request stage.
// ----------------------------------------
always_ff @(posedge i_clk)
begin
        if (i_rst)
                lu_valid_q <= 1'b0;
        else
                lu_valid_q <= i_lu_valid;
end

always_ff @(posedge i_clk)
begin
        va_q   <= i_lu_va;
        rd_q   <= i_lu_rd;
        wr_q   <= i_lu_wr;
        user_q <= i_lu_user;
end

// ----------------------------------------
// Tag compares.
// ----------------------------------------
assign sp_hit = i_sptlb_rdav &&
                (i_sptlb_rdata[SP_TLB_WDT-1:SP_TAG_LO] == va_q[31:SP_IDX_LO+IDX_W]);
assign lp_hit = i_lptlb_rdav &&
                (i_lptlb_rdata[LP_TLB_WDT-1:LP_TAG_LO] == va_q[31:LP_IDX_LO+IDX_W]);
assign se_hit = i_setlb_rdav &&
                (i_setlb_rdata[SE_TLB_WDT-1:SE_TAG_LO] == va_q[31:SE_IDX_LO+IDX_W]);
assign fp_hit = i_fptlb_rdav &&
                (i_fptlb_rdata[FP_TLB_WDT-1:FP_TAG_LO] == va_q[31:FP_IDX_LO+IDX_W]);

assign dac        = i_dac_reg[{dom, 1'b0} +: 2];
assign o_lu_valid = lu_valid_q;
assign o_lu_far   = va_q;       // Always the request VA.

always_comb
begin
        o_lu_pa        = va_q;  // Flat map when MMU off.
        o_lu_fsr       = '0;
        o_lu_walk      = 1'b0;
        o_lu_cacheable = 1'b0;
        hit            = 1'b0;
        section        = 1'b0;
        dom            = '0;
        ap             = '0;

        if (i_mmu_en && (rd_q || wr_q))
        begin
                hit = 1'b1;
                if (sp_hit)     // Small page first.
                begin
                        dom            = i_sptlb_rdata[SP_BASE_LO-1:SP_DOM_LO];
                        ap             = i_sptlb_rdata[AP_LO + 2*va_q[SP_APSEL_LO +: 2] +: 2];
                        o_lu_pa        = {i_sptlb_rdata[SP_TAG_LO-1:SP_BASE_LO],
                                          va_q[SP_IDX_LO-1:0]};
                        o_lu_cacheable = i_sptlb_rdata[CB_C_BIT];
                end
                else if (lp_hit)
                begin
                        dom            = i_lptlb_rdata[LP_BASE_LO-1:LP_DOM_LO];
                        ap             = i_lptlb_rdata[AP_LO + 2*va_q[LP_APSEL_LO +: 2] +: 2];
                        o_lu_pa        = {i_lptlb_rdata[LP_TAG_LO-1:LP_BASE_LO],
                                          va_q[LP_IDX_LO-1:0]};
                        o_lu_cacheable = i_lptlb_rdata[CB_C_BIT];
                end
                else if (se_hit)
                begin
                        section        = 1'b1;
                        dom            = i_setlb_rdata[SE_BASE_LO-1:SE_DOM_LO];
                        ap             = i_setlb_rdata[SE_DOM_LO-1:AP_LO];
                        o_lu_pa        = {i_setlb_rdata[SE_TAG_LO-1:SE_BASE_LO],
                                          va_q[SE_IDX_LO-1:0]};
                        o_lu_cacheable = i_setlb_rdata[CB_C_BIT];
                end
                else if (fp_hit)
                begin
                        dom            = i_fptlb_rdata[FP_BASE_LO-1:FP_DOM_LO];
                        ap             = i_fptlb_rdata[FP_DOM_LO-1:AP_LO];
                        o_lu_pa        = {i_fptlb_rdata[FP_TAG_LO-1:FP_BASE_LO],
                                          va_q[FP_IDX_LO-1:0]};
                        o_lu_cacheable = i_fptlb_rdata[CB_C_BIT];
                end
                else
                begin
                        hit       = 1'b0;
                        o_lu_walk = 1'b1;       // Miss everywhere means walk.
                end
        end

        if (hit)
        begin
                case (dac)
                DAC_MANAGER:    // Never faults.
                        o_lu_fsr = '0;
                DAC_CLIENT:
                        if (!apsr_ok(user_q, wr_q, {ap, i_sr}))
                                o_lu_fsr = {dom, section ? FSR_SECTION_PERM : FSR_PAGE_PERM};
                default:        // No access or reserved.
                        o_lu_fsr = {dom, section ? FSR_SECTION_DOMAIN : FSR_PAGE_DOMAIN};
                endcase
        end
end

// AP/SR table. Reaching here means rd or wr is set.
function automatic logic apsr_ok(input logic user, input logic wr, input apsr_t apsr);
        logic ok;

        casez (apsr)
        APSR_NA_NA: ok = 1'b0;
        APSR_RO_NA: ok = !user && !wr;  // Kernel read.
        APSR_RO_RO: ok = !wr;           // Reads for all.
        APSR_RW_NA: ok = !user;
        APSR_RW_RO: ok = !user || !wr;  // User read only.
        APSR_RW_RW: ok = 1'b1;
        default:    ok = 1'b0;          // Unknown AP or SR bits.
        endcase
        return ok;
endfunction

endmodule

// ==== hdl/mmu_csr_axil.sv ====
// AXI4-Lite register slave with control, domain and entry registers and TLB commands.
`timescale 1ns/1ps

module mmu_csr_axil
        import mmu_tlb_pkg::*, mmu_access_pkg::*;
(
        input  logic                  i_clk,
        input  logic                  i_rst,
        input  logic                  i_awvalid,
        output logic                  o_awready,
        input  logic [4:0]            i_awaddr,
        input  logic                  i_wvalid,
        output logic                  o_wready,
        input  logic [31:0]           i_wdata,
        output logic                  o_bvalid,
        input  logic                  i_bready,
        output logic [1:0]            o_bresp,
        input  logic                  i_arvalid,
        output logic                  o_arready,
        input  logic [4:0]            i_araddr,
        output logic                  o_rvalid,
        input  logic                  i_rready,
        output logic [31:0]           o_rdata,
        output logic [1:0]            o_rresp,
        output logic                  o_mmu_en,
        output logic [1:0]            o_sr,             // {S, R}.
        output logic [31:0]           o_dac_reg,
        output logic [SP_TLB_WDT-1:0] o_tlb_wr_data,    // Shared by all TLBs.
        output tlb_idx_t              o_tlb_wr_idx,
        output logic                  o_se_wr,
        output logic                  o_lp_wr,
        output logic                  o_sp_wr,
        output logic                  o_fp_wr,
        output logic                  o_flush
);

axil_state_t            state;
logic [31:0]            entry_lo;
logic [SP_TLB_WDT-33:0] entry_hi;       // Entry bits 50:32.
logic                   wr_go;          // AW/W handshake cycle.
logic                   cmd_go;         // Write to REG_TLB_CMD.
tlb_kind_t              cmd_kind;
logic                   ar_ack;         // AR handshake cycle.
logic [31:0]            rd_mux;

assign wr_go     = (state == AXIL_ACK);
assign o_awready = wr_go;
assign o_wready  = wr_go;
assign o_bvalid  = (state == AXIL_RESP);        // Rises as the write lands.
assign o_bresp   = 2'b00;                       // OKAY.
assign o_arready = ar_ack;
assign o_rresp   = 2'b00;

// ----------------------------------------
// Write channel.
// ----------------------------------------
always_ff @(posedge i_clk)
begin
        if (i_rst)
                state <= AXIL_IDLE;
        else
        begin
                case (state)
                AXIL_IDLE:
                        if (i_awvalid && i_wvalid)
                                state <= AXIL_ACK;
                AXIL_ACK:
                        state <= AXIL_RESP;
                default:
                        if (i_bready)
                                state <= AXIL_IDLE;
                endcase
        end
end

always_ff @(posedge i_clk)
begin
        if (i_rst)
        begin
                o_mmu_en  <= 1'b0;
                o_sr      <= '0;
                o_dac_reg <= {16{DAC_NOACCESS}};
        end
        else if (wr_go)
        begin
                case (i_awaddr)
                REG_CTRL:
                begin
                        o_mmu_en <= i_wdata[CTRL_EN_BIT];
                        o_sr     <= i_wdata[CTRL_SR_LO +: 2];
                end
                REG_DAC:
                        o_dac_reg <= i_wdata;
                default:
                        ;
                endcase
        end
end

always_ff @(posedge i_clk)
begin
        if (wr_go && (i_awaddr == REG_ENTRY_LO))
                entry_lo <= i_wdata;
        if (wr_go && (i_awaddr == REG_ENTRY_HI))
                entry_hi <= i_wdata[SP_TLB_WDT-33:0];
end

// TLB commands strobe in the handshake cycle, so the TLB writes at the BVALID edge.
assign cmd_go        = wr_go && (i_awaddr == REG_TLB_CMD);
assign cmd_kind      = tlb_kind_t'(i_wdata[CMD_KIND_LO +: 2]);
assign o_tlb_wr_idx  = i_wdata[CMD_IDX_LO +: IDX_W];
assign o_tlb_wr_data = {entry_hi, entry_lo};
assign o_se_wr       = cmd_go && i_wdata[CMD_WR_BIT] && (cmd_kind == SECTION);
assign o_lp_wr       = cmd_go && i_wdata[CMD_WR_BIT] && (cmd_kind == LPAGE);
assign o_sp_wr       = cmd_go && i_wdata[CMD_WR_BIT] && (cmd_kind == SPAGE);
assign o_fp_wr       = cmd_go && i_wdata[CMD_WR_BIT] && (cmd_kind == FPAGE);
assign o_flush       = cmd_go && i_wdata[CMD_FLUSH_BIT];

// ----------------------------------------
// Read channel.
// ----------------------------------------
always_comb
begin
        case (i_araddr)
        REG_CTRL:     rd_mux = {29'd0, o_sr, o_mmu_en};
        REG_DAC:      rd_mux = o_dac_reg;
        REG_ENTRY_LO: rd_mux = entry_lo;
        REG_ENTRY_HI: rd_mux = {{(64-SP_TLB_WDT){1'b0}}, entry_hi};
        default:      rd_mux = '0;      // Command and unmapped.
        endcase
end

always_ff @(posedge i_clk)
begin
        if (i_rst)
        begin
                ar_ack   <= 1'b0;
                o_rvalid <= 1'b0;
        end
        else
        begin
                ar_ack <= i_arvalid && !ar_ack && !o_rvalid;
                if (ar_ack)
                        o_rvalid <= 1'b1;
                else if (i_rready)
                        o_rvalid <= 1'b0;
        end
end

always_ff @(posedge i_clk)
begin
        if (ar_ack)
                o_rdata <= rd_mux;
end

endmodule

// ==== hdl/mmu_tlb_top.sv ====
// MMU lookup top: register slave, four TLBs and the result checker.
`timescale 1ns/1ps

module mmu_tlb_top
        import mmu_tlb_pkg::*, mmu_access_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_rst,
        input  logic        i_awvalid,
        output logic        o_awready,
        input  logic [4:0]  i_awaddr,
        input  logic        i_wvalid,
        output logic        o_wready,
        input  logic [31:0] i_wdata,
        output logic        o_bvalid,
        input  logic        i_bready,
        output logic [1:0]  o_bresp,
        input  logic        i_arvalid,
        output logic        o_arready,
        input  logic [4:0]  i_araddr,
        output logic        o_rvalid,
        input  logic        i_rready,
        output logic [31:0] o_rdata,
        output logic [1:0]  o_rresp,
        input  logic        i_lu_valid,
        input  va_t         i_lu_va,
        input  logic        i_lu_rd,
        input  logic        i_lu_wr,
        input  logic        i_lu_user,
        output logic        o_lu_valid,
        output va_t         o_lu_pa,
        output fsr_t        o_lu_fsr,
        output va_t         o_lu_far,
        output logic        o_lu_walk,
        output logic        o_lu_cacheable
);

logic                  mmu_en;
logic [1:0]            sr;
logic [31:0]           dac_reg;
logic [SP_TLB_WDT-1:0] tlb_wr_data;
tlb_idx_t              tlb_wr_idx;
logic                  se_wr;
logic                  lp_wr;
logic                  sp_wr;
logic                  fp_wr;
logic                  flush;
logic [SE_TLB_WDT-1:0] se_rdata;
logic [LP_TLB_WDT-1:0] lp_rdata;
logic [SP_TLB_WDT-1:0] sp_rdata;
logic [FP_TLB_WDT-1:0] fp_rdata;
logic                  se_rdav;
logic                  lp_rdav;
logic                  sp_rdav;
logic                  fp_rdav;

mmu_csr_axil u_csr (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
        .i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata),
        .o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
        .i_arvalid(i_arvalid), .o_arready(o_arready), .i_araddr(i_araddr),
        .o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp),
        .o_mmu_en(mmu_en), .o_sr(sr), .o_dac_reg(dac_reg),
        .o_tlb_wr_data(tlb_wr_data), .o_tlb_wr_idx(tlb_wr_idx),
        .o_se_wr(se_wr), .o_lp_wr(lp_wr), .o_sp_wr(sp_wr), .o_fp_wr(fp_wr),
        .o_flush(flush)
);

// ----------------------------------------
// TLBs indexed straight from the lookup VA.
// ----------------------------------------
tlb_ram #(.WDT(SE_TLB_WDT)) u_se_tlb (
        .i_clk(i_clk), .i_rst(i_rst), .i_rd_idx(i_lu_va[SE_IDX_LO +: IDX_W]),
        .i_wr_en(se_wr), .i_wr_idx(tlb_wr_idx), .i_wr_data(tlb_wr_data[SE_TLB_WDT-1:0]),
        .i_flush(flush), .o_rdata(se_rdata), .o_rdav(se_rdav)
);

tlb_ram #(.WDT(LP_TLB_WDT)) u_lp_tlb (
        .i_clk(i_clk), .i_rst(i_rst), .i_rd_idx(i_lu_va[LP_IDX_LO +: IDX_W]),
        .i_wr_en(lp_wr), .i_wr_idx(tlb_wr_idx), .i_wr_data(tlb_wr_data[LP_TLB_WDT-1:0]),
        .i_flush(flush), .o_rdata(lp_rdata), .o_rdav(lp_rdav)
);

tlb_ram #(.WDT(SP_TLB_WDT)) u_sp_tlb (
        .i_clk(i_clk), .i_rst(i_rst), .i_rd_idx(i_lu_va[SP_IDX_LO +: IDX_W]),
        .i_wr_en(sp_wr), .i_wr_idx(tlb_wr_idx), .i_wr_data(tlb_wr_data),
        .i_flush(flush), .o_rdata(sp_rdata), .o_rdav(sp_rdav)
);

tlb_ram #(.WDT(FP_TLB_WDT)) u_fp_tlb (
        .i_clk(i_clk), .i_rst(i_rst), .i_rd_idx(i_lu_va[FP_IDX_LO +: IDX_W]),
        .i_wr_en(fp_wr), .i_wr_idx(tlb_wr_idx), .i_wr_data(tlb_wr_data[FP_TLB_WDT-1:0]),
        .i_flush(flush), .o_rdata(fp_rdata), .o_rdav(fp_rdav)
);

tlb_check u_check (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_lu_valid(i_lu_valid), .i_lu_va(i_lu_va), .i_lu_rd(i_lu_rd),
        .i_lu_wr(i_lu_wr), .i_lu_user(i_lu_user),
        .i_mmu_en(mmu_en), .i_sr(sr), .i_dac_reg(dac_reg),
        .i_sptlb_rdata(sp_rdata), .i_sptlb_rdav(sp_rdav),
        .i_lptlb_rdata(lp_rdata), .i_lptlb_rdav(lp_rdav),
        .i_setlb_rdata(se_rdata), .i_setlb_rdav(se_rdav),
        .i_fptlb_rdata(fp_rdata), .i_fptlb_rdav(fp_rdav),
        .o_lu_valid(o_lu_valid), .o_lu_pa(o_lu_pa), .o_lu_fsr(o_lu_fsr),
        .o_lu_far(o_lu_far), .o_lu_walk(o_lu_walk), .o_lu_cacheable(o_lu_cacheable)
);

endmodule

// ==== tests/tb_mmu_tlb.sv ====
// Testbench for the MMU TLB lookup block: register bus driver, lookup driver and result checker.
`timescale 1ns/1ps

module tb_mmu_tlb;

localparam int MAX_CASES = 64;

logic        i_clk;
logic        i_rst;
logic        i_awvalid;
logic        o_awready;
logic [4:0]  i_awaddr;
logic        i_wvalid;
logic        o_wready;
logic [31:0] i_wdata;
logic        o_bvalid;
logic        i_bready;
logic [1:0]  o_bresp;
logic        i_arvalid;
logic        o_arready;
logic [4:0]  i_araddr;
logic        o_rvalid;
logic        i_rready;
logic [31:0] o_rdata;
logic [1:0]  o_rresp;
logic        i_lu_valid;
logic [31:0] i_lu_va;
logic        i_lu_rd;
logic        i_lu_wr;
logic        i_lu_user;
logic        o_lu_valid;
logic [31:0] o_lu_pa;
logic [7:0]  o_lu_fsr;
logic [31:0] o_lu_far;
logic        o_lu_walk;
logic        o_lu_cacheable;

logic [31:0] cases_mem [0:3*MAX_CASES-1];       // Three words per case.
logic [95:0] exp_q [$];                         // Pending lookup records.
int          due_q [$];                         // Cycle each result is due.
logic [31:0] lfsr = 32'hb76d;
int          cyc = 0;
int          limit = 1000000;                   // Real value set once cases are counted.

mmu_tlb_top dut0 (.*);

initial
begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;              // 10 ns period.
end

// ----------------------------------------
// Cycle counter and run limit.
// ----------------------------------------
always @(posedge i_clk)
begin
        cyc <= cyc + 1;
        if (cyc > limit)
        begin
                $display("Run timed out after %0d cycles, the DUT stopped answering", cyc);
                $display("TEST FAILED");
                $fatal(1, "timeout");
        end
end

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
                $display("FAIL %s got %h expected %h", name, got, exp);
                $display("TEST FAILED");
                $fatal(1, "value mismatch");
        end
endtask

// Galois LFSR, one step per bit.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
                v = (v << 1) | lfsr[0];
                lfsr = lfsr_next(lfsr);
        end
        return v;
endfunction

task automatic axil_write(input logic [4:0] addr, input logic [31:0] data);
        int delay;
        @(posedge i_clk);
        i_lu_valid <= 1'b0;
        i_awvalid  <= 1'b1;
        i_awaddr   <= addr;
        i_wvalid   <= 1'b1;
        i_wdata    <= data;
        do @(negedge i_clk); while (!(o_awready && o_wready));
        @(posedge i_clk);                       // AW and W handshake.
        i_awvalid <= 1'b0;
        i_wvalid  <= 1'b0;
        delay = rand_bits(2);
        repeat (delay) @(posedge i_clk);
        i_bready <= 1'b1;
        do @(negedge i_clk); while (!o_bvalid);
        check_eq("o_bresp", o_bresp, 32'h0);
        @(posedge i_clk);
        i_bready <= 1'b0;
endtask

task automatic axil_read(input logic [4:0] addr, input logic [31:0] exp);
        int delay;
        @(posedge i_clk);
        i_lu_valid <= 1'b0;
        i_arvalid  <= 1'b1;
        i_araddr   <= addr;
        do @(negedge i_clk); while (!o_arready);
        @(posedge i_clk);
        i_arvalid <= 1'b0;
        delay = rand_bits(2);
        repeat (delay) @(posedge i_clk);
        i_rready <= 1'b1;
        do @(negedge i_clk); while (!o_rvalid);
        check_eq("o_rdata", o_rdata, exp);
        check_eq("o_rresp", o_rresp, 32'h0);
        @(posedge i_clk);
        i_rready <= 1'b0;
endtask

// Back-to-back flag skips the idle gap.
task automatic run_lookup(input logic [31:0] ctl, input logic [31:0] va, input logic [31:0] pa);
        int gap;
        gap = ctl[24] ? 0 : rand_bits(2);
        repeat (gap)
        begin
                @(posedge i_clk);
                i_lu_valid <= 1'b0;
        end
        @(posedge i_clk);
        i_lu_valid <= 1'b1;
        i_lu_va    <= va;
        i_lu_rd    <= ctl[20];
        i_lu_wr    <= ctl[16];
        i_lu_user  <= ctl[12];
        exp_q.push_back({ctl, va, pa});
        due_q.push_back(cyc + 2);               // Sampled next edge and valid the cycle after.
endtask

// ----------------------------------------
// Lookup result checker.
// ----------------------------------------
always @(negedge i_clk)
begin : lookup_check
        logic [95:0] rec;
        logic        due_now;
        if (!i_rst)
        begin
                due_now = (due_q.size() != 0) && (due_q[0] == cyc);
                check_eq("o_lu_valid", o_lu_valid, due_now);
                if (due_now)
                begin
                        rec = exp_q.pop_front();
                        void'(due_q.pop_front());
                        check_eq("o_lu_far", o_lu_far, rec[63:32]);
                        check_eq("o_lu_fsr", o_lu_fsr, rec[71:64]);
                        check_eq("o_lu_walk", o_lu_walk, rec[73]);
                        if ((rec[71:64] == 8'h00) && !rec[73])  // PA only on a clean result.
                        begin
                                check_eq("o_lu_pa", o_lu_pa, rec[31:0]);
                                check_eq("o_lu_cacheable", o_lu_cacheable, rec[72]);
                        end
                end
        end
end

initial
begin : main_seq
        int          n_cases;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        i_rst      = 1'b1;
        i_awvalid  = 1'b0;
        i_awaddr   = '0;
        i_wvalid   = 1'b0;
        i_wdata    = '0;
        i_bready   = 1'b0;
        i_arvalid  = 1'b0;
        i_araddr   = '0;
        i_rready   = 1'b0;
        i_lu_valid = 1'b0;
        i_lu_va    = '0;
        i_lu_rd    = 1'b0;
        i_lu_wr    = 1'b0;
        i_lu_user  = 1'b0;
        for (int i = 0; i < 3*MAX_CASES; i++)
                cases_mem[i] = i;               // Kind nibble of zero ends the list.
        $readmemh("tests/mmu_tlb_cases.txt", cases_mem);
        n_cases = 0;
        while ((n_cases < MAX_CASES) && (cases_mem[3*n_cases][31:28] != 4'h0))
                n_cases++;
        limit = 20*n_cases + 200;
        repeat (10) @(posedge i_clk);
        i_rst <= 1'b0;
        for (int c = 0; c < n_cases; c++)
        begin
                w0 = cases_mem[3*c];
                w1 = cases_mem[3*c+1];
                w2 = cases_mem[3*c+2];
                case (w0[31:28])
                4'h1: axil_write(w1[4:0], w2);
                4'h2: axil_read(w1[4:0], w2);
                4'h3: run_lookup(w0, w1, w2);
                default:
                begin
                        $display("Case %0d has an unknown kind %h", c, w0[31:28]);
                        $display("TEST FAILED");
                        $fatal(1, "bad case file");
                end
                endcase
        end
        @(posedge i_clk);
        i_lu_valid <= 1'b0;
        while (due_q.size() != 0)
                @(posedge i_clk);               // Drain the pipeline.
        repeat (2) @(posedge i_clk);
        $display("TEST OK");
        $finish;
end

endmodule

// ==== tests/mmu_tlb_cases.txt ====
// Columns: control word, register offset or VA, write/read data or expected PA.
// Control digits K B R W U E FF: kind (1 write, 2 read, 3 lookup), back-to-back,
// rd, wr, user, expected {walk, C}, expected FSR.
20000000 00000000 00000000
30100000 12345678 12345678
31011000 9ABCDEF0 9ABCDEF0
10000000 00000004 00015400
20000000 00000004 00015400
10000000 00000008 0809AB5A
10000000 00000010 00000114
10000000 00000008 B2BF9A4C
10000000 0000000C 00000091
10000000 00000010 0000011D
10000000 00000008 26AF1D3B
10000000 0000000C 0003B2A2
10000000 00000010 0000010E
10000000 00000008 92345686
10000000 0000000C 00001579
10000000 00000010 00000117
20000000 00000010 00000000
10000000 00000000 00000001
20000000 00000000 00000001
30100100 4056789A 9AB6789A
3101115D 4056789A 9AB6789A
30011000 12370ABC CAFE0ABC
3110006F 12374ABC CAFE4ABC
3010106F 12378ABC CAFE8ABC
31010000 12378ABC CAFE8ABC
30101000 1237CABC CAFECABC
3101106F 1237CABC CAFECABC
30101100 76543123 89ABC123
3101117F 76543123 89ABC123
3010117F 76543C00 89ABCC00
30010100 0ABCD5A7 48D159A7
3110118F 0ABCD5A7 48D159A7
30100200 00000000 00000000
10000000 00000000 00000003
30101100 76543800 89ABC800
3101117F 76543800 89ABC800
30101000 12374ABC CAFE4ABC
10000000 00000000 00000005
30100000 12374ABC CAFE4ABC
3110106F 12374ABC CAFE4ABC
3101006F 12374ABC CAFE4ABC
10000000 00000004 0003B000
30100059 4056789A 9AB6789A
30101000 12374ABC CAFE4ABC
3110007B 76543123 89ABC123
30101100 0ABCD5A7 48D159A7
10000000 00000010 00000200
30010200 0ABCD5A7 0ABCD5A7
31100200 4056789A 4056789A

// ==== filelist.f ====
hdl/mmu_tlb_pkg.sv
hdl/mmu_access_pkg.sv
hdl/tlb_ram.sv
hdl/tlb_check.sv
hdl/mmu_csr_axil.sv
hdl/mmu_tlb_top.sv
tests/tb_mmu_tlb.sv

// ==== Bender.yml ====
package:
  name: mmu_tlb

sources:
  - hdl/mmu_tlb_pkg.sv
  - hdl/mmu_access_pkg.sv
  - hdl/tlb_ram.sv
  - hdl/tlb_check.sv
  - hdl/mmu_csr_axil.sv
  - hdl/mmu_tlb_top.sv
  - target: test
    files:
      - tests/tb_mmu_tlb.sv
